//--- design/mdu_consts.svh
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Width of one architectural data word
`define MDU_DATA_W 32

////////////////////////////////////////////////////////////////////////////
// Latencies, counted from the accepting edge to the commit edge
////////////////////////////////////////////////////////////////////////////

// Multiply, signed or unsigned
`define MDU_MULT_CYCLES 4

// Divide, signed or unsigned
`define MDU_DIV_CYCLES 9

// Opcode field position in the instruction word
`define MDU_OPCODE_MSB 31
`define MDU_OPCODE_LSB 26

`endif

//--- design/mduIsaPkg.sv
`default_nettype none

package mduIsaPkg;

	////////////////////////////////////////////////////////////////////////////
	// MDU operations as seen after decode
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		NOP   = 4'd0,
		MULT  = 4'd1,
		MULTU = 4'd2,
		DIV   = 4'd3,
		DIVU  = 4'd4,
		MFHI  = 4'd5,
		MFLO  = 4'd6,
		MTHI  = 4'd7,
		MTLO  = 4'd8
	} mduOpE;

	////////////////////////////////////////////////////////////////////////////
	// R-type encodings
	////////////////////////////////////////////////////////////////////////////

	// SPECIAL major opcode, all R-type MDU instructions live here
	localparam logic [5:0] opSpecial = 6'h00;

	// Funct field codes
	localparam logic [5:0] functMfhi  = 6'h10;
	localparam logic [5:0] functMthi  = 6'h11;
	localparam logic [5:0] functMflo  = 6'h12;
	localparam logic [5:0] functMtlo  = 6'h13;
	localparam logic [5:0] functMult  = 6'h18;
	localparam logic [5:0] functMultu = 6'h19;
	localparam logic [5:0] functDiv   = 6'h1a;
	localparam logic [5:0] functDivu  = 6'h1b;

endpackage

`default_nettype wire

//--- design/mduPipePkg.sv
`default_nettype none

`include "mdu_consts.svh"

package mduPipePkg;

	////////////////////////////////////////////////////////////////////////////
	// Issue to arithmetic engine
	////////////////////////////////////////////////////////////////////////////

	// Operands travel with the op, start marks the accepted cycle
	typedef struct packed {
		mduIsaPkg::mduOpE        op;
		logic [`MDU_DATA_W-1:0] srcA;
		logic [`MDU_DATA_W-1:0] srcB;
		logic                   start;
	} mduReqS;

	////////////////////////////////////////////////////////////////////////////
	// Issue to HI/LO registers
	////////////////////////////////////////////////////////////////////////////

	// Move-to strobes, shared write word, move-from select
	typedef struct packed {
		logic                   mtHi;
		logic                   mtLo;
		logic [`MDU_DATA_W-1:0] wrData;
		mduIsaPkg::mduOpE        rdSel;
	} hiLoCmdS;

	////////////////////////////////////////////////////////////////////////////
	// Arithmetic result, one 64-bit word seen two ways
	////////////////////////////////////////////////////////////////////////////

	// Remainder in hi, quotient in lo
	typedef struct packed {
		logic [`MDU_DATA_W-1:0] hi;
		logic [`MDU_DATA_W-1:0] lo;
	} hiLoPairS;

	typedef union packed {
		logic [2*`MDU_DATA_W-1:0] product;
		hiLoPairS                 pair;
	} mduResultU;

endpackage

`default_nettype wire

//--- design/mduIssue.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module mduIssue (
	input  logic [31:0]             instr,
	input  logic                    instrValid,
	input  logic [`MDU_DATA_W-1:0]  srcA,
	input  logic [`MDU_DATA_W-1:0]  srcB,
	input  logic                    busy,
	output mduPipePkg::mduReqS      req,
	output mduPipePkg::hiLoCmdS     hiLoCmd,
	output logic                    stall
);

	mduIsaPkg::mduOpE op;
	logic             isMdu;
	logic             accept;
	logic             isArith;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		op = mduIsaPkg::NOP;
		// Only SPECIAL opcode carries MDU functs
		if (instr[`MDU_OPCODE_MSB:`MDU_OPCODE_LSB] == mduIsaPkg::opSpecial) begin
			case (instr[5:0])
				mduIsaPkg::functMult:  op = mduIsaPkg::MULT;
				mduIsaPkg::functMultu: op = mduIsaPkg::MULTU;
				mduIsaPkg::functDiv:   op = mduIsaPkg::DIV;
				mduIsaPkg::functDivu:  op = mduIsaPkg::DIVU;
				mduIsaPkg::functMfhi:  op = mduIsaPkg::MFHI;
				mduIsaPkg::functMflo:  op = mduIsaPkg::MFLO;
				mduIsaPkg::functMthi:  op = mduIsaPkg::MTHI;
				mduIsaPkg::functMtlo:  op = mduIsaPkg::MTLO;
				default:               op = mduIsaPkg::NOP;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stall and accept
	////////////////////////////////////////////////////////////////////////////

	// Any MDU op waits out a computation, other instructions pass
	assign isMdu   = instrValid && (op != mduIsaPkg::NOP);
	assign stall   = isMdu && busy;
	assign accept  = isMdu && !busy;
	assign isArith = (op == mduIsaPkg::MULT) || (op == mduIsaPkg::MULTU) ||
	                 (op == mduIsaPkg::DIV)  || (op == mduIsaPkg::DIVU);

	// Engine request, start only in the accepting cycle
	always_comb begin
		req.op    = op;
		req.srcA  = srcA;
		req.srcB  = srcB;
		req.start = accept && isArith;
	end

	// Move-to strobes and move-from select, already qualified by accept
	always_comb begin
		hiLoCmd.mtHi   = accept && (op == mduIsaPkg::MTHI);
		hiLoCmd.mtLo   = accept && (op == mduIsaPkg::MTLO);
		hiLoCmd.wrData = srcA;
		if (accept && ((op == mduIsaPkg::MFHI) || (op == mduIsaPkg::MFLO)))
			hiLoCmd.rdSel = op;
		else
			hiLoCmd.rdSel = mduIsaPkg::NOP;
	end

endmodule

`default_nettype wire

//--- design/mduArith.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module mduArith (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   clr,
	input  mduPipePkg::mduReqS     req,
	output logic                   busy,
	output logic                   commit,
	output mduPipePkg::mduResultU  result
);

	localparam int DataW = `MDU_DATA_W;
	localparam int CntW  = $clog2(`MDU_DIV_CYCLES);

	logic [CntW-1:0]          count;
	logic                     isDiv;
	logic signed [2*DataW-1:0] sProd;
	logic [2*DataW-1:0]       uProd;
	logic                     divByZero;
	logic                     sOverflow;
	logic [DataW-1:0]         sDivisor;
	logic [DataW-1:0]         uDivisor;
	logic signed [DataW-1:0]  sQuot;
	logic signed [DataW-1:0]  sRem;
	logic [DataW-1:0]         uQuot;
	logic [DataW-1:0]         uRem;
	mduPipePkg::mduResultU    nextResult;

	////////////////////////////////////////////////////////////////////////////
	// Combinational datapath, sampled on start
	////////////////////////////////////////////////////////////////////////////

	// Full 64-bit products, operands extended by signedness
	assign sProd = $signed(req.srcA) * $signed(req.srcB);
	assign uProd = req.srcA * req.srcB;

	// Special divisor cases
	assign divByZero = (req.srcB == '0);
	assign sOverflow = (req.srcA == {1'b1, {(DataW-1){1'b0}}}) && (&req.srcB);

	// Divide by one stands in for the special cases
	// gives quotient = dividend, remainder = 0, which is the wrap result
	assign sDivisor = (divByZero || sOverflow) ? DataW'(1) : req.srcB;
	assign uDivisor = divByZero ? DataW'(1) : req.srcB;

	assign sQuot = $signed(req.srcA) / $signed(sDivisor);
	assign sRem  = $signed(req.srcA) % $signed(sDivisor);
	assign uQuot = req.srcA / uDivisor;
	assign uRem  = req.srcA % uDivisor;

	always_comb begin
		nextResult = '0;
		case (req.op)
			mduIsaPkg::MULT:  nextResult.product = sProd;
			mduIsaPkg::MULTU: nextResult.product = uProd;
			mduIsaPkg::DIV: begin
				nextResult.pair.hi = divByZero ? req.srcA : sRem;
				nextResult.pair.lo = divByZero ? '1 : sQuot;
			end
			mduIsaPkg::DIVU: begin
				nextResult.pair.hi = divByZero ? req.srcA : uRem;
				nextResult.pair.lo = divByZero ? '1 : uQuot;
			end
			default: nextResult = '0;
		endcase
	end

	// Held result, committed later
	always_ff @(posedge clk) begin
		if (req.start)
			result <= nextResult;
	end

	////////////////////////////////////////////////////////////////////////////
	// Countdown
	////////////////////////////////////////////////////////////////////////////

	assign isDiv = (req.op == mduIsaPkg::DIV) || (req.op == mduIsaPkg::DIVU);

	// Loaded with latency minus one, commit sits in the cycle where it hits zero
	always_ff @(posedge clk) begin
		if (!rstN || clr) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (req.start) begin
			busy  <= 1'b1;
			count <= isDiv ? CntW'(`MDU_DIV_CYCLES - 1) : CntW'(`MDU_MULT_CYCLES - 1);
		end else if (busy) begin
			if (count == '0)
				busy <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	// HI/LO load on the edge that drops busy
	assign commit = busy && (count == '0);

endmodule

`default_nettype wire

//--- design/hiLoRegs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module hiLoRegs (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   clr,
	input  mduPipePkg::hiLoCmdS    cmd,
	input  logic                   commit,
	input  mduPipePkg::mduResultU  result,
	output logic [`MDU_DATA_W-1:0] rdData
);

	logic [`MDU_DATA_W-1:0] hi;
	logic [`MDU_DATA_W-1:0] lo;

	////////////////////////////////////////////////////////////////////////////
	// Architectural HI and LO
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN || clr) begin
			hi <= '0;
			lo <= '0;
		end else begin
			// Engine result, pair view covers both mult and div
			if (commit) begin
				hi <= result.pair.hi;
				lo <= result.pair.lo;
			end
			// Move-to, each strobe touches its own register
			if (cmd.mtHi)
				hi <= cmd.wrData;
			if (cmd.mtLo)
				lo <= cmd.wrData;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Move-from read
	////////////////////////////////////////////////////////////////////////////

	// Zero unless an accepted mfhi/mflo is presented
	always_comb begin
		case (cmd.rdSel)
			mduIsaPkg::MFHI: rdData = hi;
			mduIsaPkg::MFLO: rdData = lo;
			default:         rdData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/mduTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module mduTop (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   clr,
	input  logic                   instrValid,
	input  logic [31:0]            instr,
	input  logic [`MDU_DATA_W-1:0] srcA,
	input  logic [`MDU_DATA_W-1:0] srcB,
	output logic                   stall,
	output logic [`MDU_DATA_W-1:0] mfOut
);

	mduPipePkg::mduReqS    req;
	mduPipePkg::hiLoCmdS   hiLoCmd;
	mduPipePkg::mduResultU result;
	logic                  busy;
	logic                  commit;

	// Decode, stall, command generation
	mduIssue uIssue (
		.instr      (instr),
		.instrValid (instrValid),
		.srcA       (srcA),
		.srcB       (srcB),
		.busy       (busy),
		.req        (req),
		.hiLoCmd    (hiLoCmd),
		.stall      (stall)
	);

	// Multi-cycle mult/div engine
	mduArith uArith (
		.clk    (clk),
		.rstN   (rstN),
		.clr    (clr),
		.req    (req),
		.busy   (busy),
		.commit (commit),
		.result (result)
	);

	// HI/LO state and move-from read
	hiLoRegs uHiLo (
		.clk    (clk),
		.rstN   (rstN),
		.clr    (clr),
		.cmd    (hiLoCmd),
		.commit (commit),
		.result (result),
		.rdData (mfOut)
	);

endmodule

`default_nettype wire

//--- test/mdu_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module mduAssertions (
	input logic                   clk,
	input logic                   rstN,
	input logic                   clr,
	input logic                   instrValid,
	input logic [31:0]            instr,
	input logic [`MDU_DATA_W-1:0] srcA,
	input logic [`MDU_DATA_W-1:0] srcB,
	input logic                   stall,
	input logic [`MDU_DATA_W-1:0] mfOut
);

	localparam int DataW = `MDU_DATA_W;

	logic [DataW-1:0]   shHi;
	logic [DataW-1:0]   shLo;
	logic [2*DataW-1:0] pending;
	logic [3:0]         cnt;
	logic [DataW-1:0]   expMf;
	logic [5:0]         funct;
	logic               special;
	logic               sgn;
	logic               isMul;
	logic               isDiv;
	logic               isMfhi;
	logic               isMflo;
	logic               isMthi;
	logic               isMtlo;
	logic               isMdu;
	logic               accept;
	logic               expStall;
	int                 stallErrs = 0;
	int                 mfErrs = 0;
	int                 otherErrs = 0;
	int                 clrErrs = 0;

	// Signed or unsigned 64-bit product from sign-extended operands
	function automatic logic [2*DataW-1:0] fullProduct(input logic [DataW-1:0] a,
		input logic [DataW-1:0] b, input logic sgnOp);
		logic [2*DataW-1:0] wideA;
		logic [2*DataW-1:0] wideB;
		wideA = {{DataW{sgnOp & a[DataW-1]}}, a};
		wideB = {{DataW{sgnOp & b[DataW-1]}}, b};
		return wideA * wideB;
	endfunction

	// Remainder in the upper word, quotient in the lower word
	function automatic logic [2*DataW-1:0] quotRem(input logic [DataW-1:0] a,
		input logic [DataW-1:0] b, input logic sgnOp);
		logic             negA;
		logic             negB;
		logic [DataW:0]   magA;
		logic [DataW:0]   magB;
		logic [DataW-1:0] q;
		logic [DataW-1:0] r;
		if (b == '0)
			return {a, {DataW{1'b1}}};
		negA = sgnOp & a[DataW-1];
		negB = sgnOp & b[DataW-1];
		// Magnitudes one bit wider so min integer stays positive
		magA = negA ? ({1'b1, {DataW{1'b0}}} - {1'b0, a}) : {1'b0, a};
		magB = negB ? ({1'b1, {DataW{1'b0}}} - {1'b0, b}) : {1'b0, b};
		q = DataW'(magA / magB);
		r = DataW'(magA % magB);
		if (negA ^ negB)
			q = -q;
		// Remainder takes the sign of the dividend
		if (negA)
			r = -r;
		return {r, q};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Decode of the presented instruction
	////////////////////////////////////////////////////////////////////////////

	assign funct   = instr[5:0];
	assign special = instr[`MDU_OPCODE_MSB:`MDU_OPCODE_LSB] == mduIsaPkg::opSpecial;
	assign isMul   = special && (funct == mduIsaPkg::functMult || funct == mduIsaPkg::functMultu);
	assign isDiv   = special && (funct == mduIsaPkg::functDiv || funct == mduIsaPkg::functDivu);
	assign isMfhi  = special && funct == mduIsaPkg::functMfhi;
	assign isMflo  = special && funct == mduIsaPkg::functMflo;
	assign isMthi  = special && funct == mduIsaPkg::functMthi;
	assign isMtlo  = special && funct == mduIsaPkg::functMtlo;
	assign sgn     = funct == mduIsaPkg::functMult || funct == mduIsaPkg::functDiv;
	assign isMdu   = instrValid && (isMul || isDiv || isMfhi || isMflo || isMthi || isMtlo);

	// Unit counts as busy while the shadow countdown runs
	assign expStall = isMdu && (cnt != 4'd0);
	assign accept   = isMdu && (cnt == 4'd0);

	////////////////////////////////////////////////////////////////////////////
	// Shadow HI/LO model
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN || clr) begin
			shHi <= '0;
			shLo <= '0;
			cnt  <= '0;
		end else begin
			// Commit edge
			if (cnt == 4'd1) begin
				shHi <= pending[2*DataW-1:DataW];
				shLo <= pending[DataW-1:0];
			end
			if (cnt != 4'd0)
				cnt <= cnt - 4'd1;
			if (accept && (isMul || isDiv)) begin
				pending <= isDiv ? quotRem(srcA, srcB, sgn) : fullProduct(srcA, srcB, sgn);
				cnt     <= isDiv ? 4'(`MDU_DIV_CYCLES) : 4'(`MDU_MULT_CYCLES);
			end
			if (accept && isMthi)
				shHi <= srcA;
			if (accept && isMtlo)
				shLo <= srcA;
		end
	end

	always_comb begin
		expMf = '0;
		if (accept && isMfhi)
			expMf = shHi;
		else if (accept && isMflo)
			expMf = shLo;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	aStall: assert property (@(posedge clk) disable iff (!rstN) stall == expStall)
		else begin
			stallErrs++;
			$error("FAILED t=%0t stall expected %b got %b", $time, expStall, stall);
		end

	// Covers products, quotients, move-to values and the zero read
	aMfOut: assert property (@(posedge clk) disable iff (!rstN) mfOut == expMf)
		else begin
			mfErrs++;
			$error("FAILED t=%0t mfOut expected %h got %h", $time, expMf, mfOut);
		end

	aNonMdu: assert property (@(posedge clk) disable iff (!rstN) !isMdu |-> !stall)
		else begin
			otherErrs++;
			$error("FAILED t=%0t stall expected 0 got 1 for a non-MDU instruction", $time);
		end

	aClear: assert property (@(posedge clk) disable iff (!rstN) $past(clr || !rstN) |-> !stall)
		else begin
			clrErrs++;
			$error("FAILED t=%0t stall expected 0 got 1 right after clear", $time);
		end

endmodule

`default_nettype wire

//--- test/mduTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_consts.svh"

module mduTb;

	// Instruction counts of each sequence set the cycle limit
	localparam int cornerOps   = 4 * 5 * 5 * 3;
	localparam int directedOps = 45;
	localparam int randomIters = 30;
	localparam int seqOps      = cornerOps + directedOps + 3 * randomIters;
	localparam int maxCycles   = 2 * seqOps * `MDU_DIV_CYCLES;

	logic                   clk = 1'b0;
	logic                   rstN;
	logic                   clr;
	logic                   instrValid;
	logic [31:0]            instr;
	logic [`MDU_DATA_W-1:0] srcA;
	logic [`MDU_DATA_W-1:0] srcB;
	logic                   stall;
	logic [`MDU_DATA_W-1:0] mfOut;
	int                     seed = 59978;
	int                     cycleCount = 0;
	int                     errTotal;
	logic [31:0]            corners [0:4];
	logic [5:0]             arithFuncts [0:3];

	mduTop UUT (.*);

	bind mduTop mduAssertions uChk (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("Timeout after %0d cycles, the unit stopped making progress", cycleCount);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic logic [31:0] encodeR(input logic [5:0] opcode, input logic [5:0] funct);
		return {opcode, 5'd3, 5'd4, 5'd0, 5'd0, funct};
	endfunction

	// Hold the instruction until the edge that accepts it
	task automatic issueInstr(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		logic wasStalled;
		instr      = encodeR(mduIsaPkg::opSpecial, funct);
		srcA       = a;
		srcB       = b;
		instrValid = 1'b1;
		do begin
			@(posedge clk);
			wasStalled = stall;
		end while (wasStalled);
		#1;
		instrValid = 1'b0;
	endtask

	// Non-MDU word presented for one cycle only
	task automatic presentOther(input logic [31:0] word);
		instr      = word;
		instrValid = 1'b1;
		@(posedge clk);
		#1;
		instrValid = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		instrValid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic readHiLo();
		issueInstr(mduIsaPkg::functMfhi, 32'd0, 32'd0);
		issueInstr(mduIsaPkg::functMflo, 32'd0, 32'd0);
	endtask

	// Reads are presented at once, so they stall through the computation
	task automatic arithThenRead(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		issueInstr(funct, a, b);
		readHiLo();
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		int          sel;
		instrValid = 1'b0;
		instr      = '0;
		srcA       = '0;
		srcB       = '0;
		clr        = 1'b0;
		rstN       = 1'b0;
		corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		arithFuncts = '{mduIsaPkg::functMult, mduIsaPkg::functMultu,
		                mduIsaPkg::functDiv, mduIsaPkg::functDivu};
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Straight out of reset
		readHiLo();

		// Corner operands include divide by zero and min integer over minus one
		for (int f = 0; f < 4; f++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					arithThenRead(arithFuncts[f], corners[i], corners[j]);

		// Non-MDU instructions while busy include one outside SPECIAL
		issueInstr(mduIsaPkg::functMult, 32'h1234_5678, 32'h9abc_def0);
		presentOther(encodeR(mduIsaPkg::opSpecial, 6'h20));
		presentOther(encodeR(6'h08, mduIsaPkg::functMult));
		// Move-to presented during the same multiply waits for its commit
		issueInstr(mduIsaPkg::functMthi, 32'h5a5a_a5a5, 32'd0);
		readHiLo();

		// Move-to writes followed by idle cycles to see them held
		issueInstr(mduIsaPkg::functMthi, 32'hcafe_0001, 32'd0);
		readHiLo();
		issueInstr(mduIsaPkg::functMtlo, 32'h0bad_f00d, 32'd0);
		readHiLo();
		idleCycles(5);
		readHiLo();

		// Read select without a valid instruction
		instr = encodeR(mduIsaPkg::opSpecial, mduIsaPkg::functMfhi);
		idleCycles(2);

		// Clear in the middle of a divide
		issueInstr(mduIsaPkg::functDiv, 32'hffff_ff00, 32'd7);
		idleCycles(3);
		clr = 1'b1;
		@(posedge clk);
		#1;
		clr = 1'b0;
		// Reads right after the clear see no computation and zeroed registers
		readHiLo();
		// Past the cancelled commit edge
		idleCycles(12);
		readHiLo();

		// Random ops with every fifth divisor forced to zero
		for (int k = 0; k < randomIters; k++) begin
			a   = $random(seed);
			b   = $random(seed);
			sel = $random(seed) & 3;
			if (k % 5 == 0)
				b = '0;
			arithThenRead(arithFuncts[sel], a, b);
		end
		idleCycles(3);

		errTotal = UUT.uChk.stallErrs + UUT.uChk.mfErrs + UUT.uChk.otherErrs +
		           UUT.uChk.clrErrs;
		$display("Errors: stall %0d, mfOut %0d, non-MDU stall %0d, clear %0d, total %0d",
		         UUT.uChk.stallErrs, UUT.uChk.mfErrs, UUT.uChk.otherErrs,
		         UUT.uChk.clrErrs, errTotal);
		if (errTotal == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/mduIsaPkg.sv
design/mduPipePkg.sv
design/mduIssue.sv
design/mduArith.sv
design/hiLoRegs.sv
design/mduTop.sv
test/mdu_assertions.sv
test/mduTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
SIMFLAGS  = +verilator+error+limit+1000
TOP       = mduTb
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
